// File: design/dispatch_sizes_pkg.sv
package dispatch_sizes_pkg;

  // memory bus widths
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;

  // cpus hanging off the dispatcher
  localparam int CPU_QUANTITY = 4;

  // cpu numbers and the pool counters share this width
  localparam int CPU_NUM_W = 8;

  // whole select word as the cpus see it
  localparam int CPU_SEL_W = 16;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;
  typedef logic [CPU_NUM_W-1:0] cpu_num_t;

  // field layout of the select word, msb first
  typedef struct packed {
    // turn goes to the active cpu named in cpu_number
    logic active_pool;
    // turn offered to any cpu that has not started yet
    logic nonactive_pool;
    // always zero
    logic [CPU_SEL_W-2-CPU_NUM_W-1:0] spare;
    cpu_num_t cpu_number;
  } cpu_sel_fields_t;

  // rotor fills in fields, cpus compare the raw word
  typedef union packed {
    logic [CPU_SEL_W-1:0] raw;
    cpu_sel_fields_t fields;
  } cpu_sel_u;

endpackage

// File: design/dispatch_codes_pkg.sv
package dispatch_codes_pkg;

  // message from the turn holder
  localparam int CPU_MSG_W = 8;

  typedef logic [CPU_MSG_W-1:0] cpu_msg_t;

  // turn handed back with nothing to report
  localparam cpu_msg_t CPU_R_NONE = 8'd0;
  // a cpu from the non-active pool has started
  localparam cpu_msg_t CPU_R_START = 8'd1;
  // an active cpu has finished
  localparam cpu_msg_t CPU_R_END = 8'd2;

  // dispatcher fsm
  typedef enum logic [2:0] {
    // pick next turn or hand out the bus
    CTL_CPU_LOOP = 3'd0,
    // wait for the holder's answer
    CTL_CPU_CMD = 3'd1,
    // memory access in flight
    CTL_MEM_WORK = 3'd2,
    // done pulse toward the cpu
    CTL_MEM_FINISH = 3'd3,
    // external master owns the bus
    CTL_EXT_BUS = 3'd4
  } ctl_state_e;

endpackage

// File: design/cpu_rotor.sv
`timescale 1ns/1ps

module cpu_rotor (
  input  logic                         clk,
  input  logic                         ext_rst_e,
  input  logic                         advance,
  input  logic                         cpu_started,
  input  logic                         cpu_ended,
  output dispatch_sizes_pkg::cpu_sel_u cpu_sel
);

  // pool bookkeeping
  dispatch_sizes_pkg::cpu_num_t active_cnt;
  dispatch_sizes_pkg::cpu_num_t nonactive_cnt;

  // last active cpu that held a turn
  dispatch_sizes_pkg::cpu_num_t cur_num;
  dispatch_sizes_pkg::cpu_num_t step_num;
  dispatch_sizes_pkg::cpu_num_t last_num;

  // previous choice was a non-active offer
  logic offered;
  logic do_offer;

  dispatch_sizes_pkg::cpu_sel_u next_sel;

  // highest active number, only meaningful with active_cnt above zero
  assign last_num = active_cnt - 8'd1;

  // offers alternate with round-robin steps while anyone is waiting
  assign do_offer = (nonactive_cnt != 8'd0) && !offered;

  always_comb begin
    // wrap back to 0 after the last active cpu
    if (active_cnt == 8'd0) begin
      step_num = 8'd0;
    end else if (cur_num >= last_num) begin
      step_num = 8'd0;
    end else begin
      step_num = cur_num + 8'd1;
    end

    next_sel = '0;
    if (do_offer) begin
      next_sel.fields.nonactive_pool = 1'b1;
      next_sel.fields.cpu_number = 8'd0;
    end else begin
      next_sel.fields.active_pool = 1'b1;
      next_sel.fields.cpu_number = step_num;
    end
  end

  always_ff @(posedge clk) begin
    if (ext_rst_e) begin
      active_cnt <= 8'd0;
      nonactive_cnt <= dispatch_sizes_pkg::cpu_num_t'(dispatch_sizes_pkg::CPU_QUANTITY);
      cur_num <= 8'd0;
      offered <= 1'b0;
      cpu_sel <= '0;
    end else begin
      // one cpu moves between the pools
      if (cpu_started) begin
        active_cnt <= active_cnt + 8'd1;
        nonactive_cnt <= nonactive_cnt - 8'd1;
      end else if (cpu_ended) begin
        active_cnt <= active_cnt - 8'd1;
        nonactive_cnt <= nonactive_cnt + 8'd1;
      end

      if (advance) begin
        cpu_sel <= next_sel;
        offered <= do_offer;
        // the offer leaves the round-robin position alone
        if (!do_offer) begin
          cur_num <= step_num;
        end
      end
    end
  end

endmodule

// File: design/mem_proxy.sv
`timescale 1ns/1ps

module mem_proxy (
  input  logic                      clk,
  input  logic                      ext_rst_e,
  input  logic                      go,
  input  logic                      we,
  input  dispatch_sizes_pkg::addr_t addr,
  input  dispatch_sizes_pkg::data_t wdata,
  output logic                      done,
  output dispatch_sizes_pkg::data_t rdata,
  output logic                      mem_cyc,
  output logic                      mem_stb,
  output logic                      mem_we,
  output dispatch_sizes_pkg::addr_t mem_adr,
  output dispatch_sizes_pkg::data_t mem_dat_wr,
  input  dispatch_sizes_pkg::data_t mem_dat_rd,
  input  logic                      mem_ack
);

  // address of the open cycle
  dispatch_sizes_pkg::addr_t adr_r;

  // ack seen on the open cycle
  logic ack_hit;

  assign ack_hit = mem_cyc && mem_stb && mem_ack;

  // bus address parks at zero between cycles
  assign mem_adr = mem_cyc ? adr_r : '0;

  // wishbone classic handshake
  always_ff @(posedge clk) begin
    if (ext_rst_e) begin
      mem_cyc <= 1'b0;
      mem_stb <= 1'b0;
      mem_we <= 1'b0;
      done <= 1'b0;
    end else begin
      done <= 1'b0;
      if (!mem_cyc) begin
        // a new request opens the cycle on the next edge
        if (go) begin
          mem_cyc <= 1'b1;
          mem_stb <= 1'b1;
          mem_we <= we;
        end
      end else if (ack_hit) begin
        // slow ack just keeps everything held
        mem_cyc <= 1'b0;
        mem_stb <= 1'b0;
        mem_we <= 1'b0;
        done <= 1'b1;
      end
    end
  end

  // request payload, taken with go
  always_ff @(posedge clk) begin
    if (go && !mem_cyc) begin
      adr_r <= addr;
      mem_dat_wr <= wdata;
    end
  end

  // read data, valid together with done
  always_ff @(posedge clk) begin
    if (ack_hit) begin
      rdata <= mem_dat_rd;
    end
  end

endmodule

// File: design/dispatch_ctl.sv
`timescale 1ns/1ps

module dispatch_ctl (
  input  logic                         clk,
  input  logic                         ext_rst_e,
  input  dispatch_sizes_pkg::cpu_sel_u cpu_sel,
  input  logic                         proxy_done,
  input  dispatch_sizes_pkg::data_t    proxy_rdata,
  output logic                         advance,
  output logic                         cpu_started,
  output logic                         cpu_ended,
  output logic                         proxy_go,
  output logic                         proxy_we,
  output dispatch_sizes_pkg::addr_t    proxy_addr,
  output dispatch_sizes_pkg::data_t    proxy_wdata,
  output logic                         cpu_q,
  output dispatch_sizes_pkg::cpu_sel_u cpu_index,
  input  logic                         ext_cpu_e,
  input  dispatch_codes_pkg::cpu_msg_t cpu_msg,
  input  logic                         read_q,
  input  logic                         write_q,
  input  dispatch_sizes_pkg::addr_t    cpu_addr,
  input  dispatch_sizes_pkg::data_t    cpu_wdata,
  output logic                         read_dn,
  output logic                         write_dn,
  output dispatch_sizes_pkg::data_t    cpu_rdata,
  input  logic                         ext_bus_q,
  output logic                         ext_bus_allow
);

  dispatch_codes_pkg::ctl_state_e state;

  // access kind kept for the done pulse
  logic is_write;

  // holder asks for memory
  logic mem_req;
  logic req_write;

  // holder answers with a message
  logic msg_take;

  assign mem_req = read_q || write_q;
  // read wins if both are raised
  assign req_write = write_q && !read_q;
  assign msg_take = (state == dispatch_codes_pkg::CTL_CPU_CMD) && !mem_req && ext_cpu_e;

  // bus request beats the next turn
  assign advance = (state == dispatch_codes_pkg::CTL_CPU_LOOP) && !ext_bus_q && !ext_cpu_e;

  // rotor output is already settled when cpu_q goes high
  assign cpu_index = cpu_sel;

  // request straight to the proxy, captured there with go
  assign proxy_go = (state == dispatch_codes_pkg::CTL_CPU_CMD) && mem_req;
  assign proxy_we = req_write;
  assign proxy_addr = cpu_addr;
  assign proxy_wdata = cpu_wdata;

  // pool changes reach the rotor before the next loop
  always_comb begin
    cpu_started = 1'b0;
    cpu_ended = 1'b0;
    if (msg_take) begin
      case (cpu_msg)
        dispatch_codes_pkg::CPU_R_START: cpu_started = 1'b1;
        dispatch_codes_pkg::CPU_R_END: cpu_ended = 1'b1;
        dispatch_codes_pkg::CPU_R_NONE: begin
          // plain give-back, pools unchanged
        end
        default: begin
          // unknown codes are treated as a give-back
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (ext_rst_e) begin
      state <= dispatch_codes_pkg::CTL_CPU_LOOP;
      cpu_q <= 1'b0;
      read_dn <= 1'b0;
      write_dn <= 1'b0;
      is_write <= 1'b0;
      ext_bus_allow <= 1'b0;
    end else begin
      // turn strobe follows advance by one edge
      cpu_q <= advance;

      case (state)
        dispatch_codes_pkg::CTL_CPU_LOOP: begin
          if (ext_bus_q) begin
            state <= dispatch_codes_pkg::CTL_EXT_BUS;
          end else if (!ext_cpu_e) begin
            state <= dispatch_codes_pkg::CTL_CPU_CMD;
          end
        end

        dispatch_codes_pkg::CTL_CPU_CMD: begin
          // stay here until the holder answers
          if (mem_req) begin
            is_write <= req_write;
            state <= dispatch_codes_pkg::CTL_MEM_WORK;
          end else if (ext_cpu_e) begin
            state <= dispatch_codes_pkg::CTL_CPU_LOOP;
          end
        end

        dispatch_codes_pkg::CTL_MEM_WORK: begin
          if (proxy_done) begin
            read_dn <= !is_write;
            write_dn <= is_write;
            state <= dispatch_codes_pkg::CTL_MEM_FINISH;
          end
        end

        dispatch_codes_pkg::CTL_MEM_FINISH: begin
          // single cycle, done pulse ends here
          read_dn <= 1'b0;
          write_dn <= 1'b0;
          state <= dispatch_codes_pkg::CTL_CPU_LOOP;
        end

        dispatch_codes_pkg::CTL_EXT_BUS: begin
          if (ext_bus_q) begin
            ext_bus_allow <= 1'b1;
          end else begin
            ext_bus_allow <= 1'b0;
            state <= dispatch_codes_pkg::CTL_CPU_LOOP;
          end
        end

        default: begin
          state <= dispatch_codes_pkg::CTL_CPU_LOOP;
        end
      endcase
    end
  end

  // read data toward the cpu, valid with read_dn
  always_ff @(posedge clk) begin
    if (proxy_done && !is_write) begin
      cpu_rdata <= proxy_rdata;
    end
  end

endmodule

// File: design/dispatcher_of_cpus.sv
`timescale 1ns/1ps

module dispatcher_of_cpus (
  input  logic                         clk,
  input  logic                         ext_rst_e,
  // cpu side
  output logic                         cpu_q,
  output dispatch_sizes_pkg::cpu_sel_u cpu_index,
  input  logic                         ext_cpu_e,
  input  dispatch_codes_pkg::cpu_msg_t cpu_msg,
  input  logic                         read_q,
  input  logic                         write_q,
  input  dispatch_sizes_pkg::addr_t    cpu_addr,
  input  dispatch_sizes_pkg::data_t    cpu_wdata,
  output logic                         read_dn,
  output logic                         write_dn,
  output dispatch_sizes_pkg::data_t    cpu_rdata,
  // external bus master
  input  logic                         ext_bus_q,
  output logic                         ext_bus_allow,
  // wishbone toward memory
  output logic                         mem_cyc,
  output logic                         mem_stb,
  output logic                         mem_we,
  output dispatch_sizes_pkg::addr_t    mem_adr,
  output dispatch_sizes_pkg::data_t    mem_dat_wr,
  input  dispatch_sizes_pkg::data_t    mem_dat_rd,
  input  logic                         mem_ack
);

  // fsm to rotor
  logic advance;
  logic cpu_started;
  logic cpu_ended;
  dispatch_sizes_pkg::cpu_sel_u cpu_sel;

  // fsm to memory proxy
  logic proxy_go;
  logic proxy_we;
  dispatch_sizes_pkg::addr_t proxy_addr;
  dispatch_sizes_pkg::data_t proxy_wdata;
  logic proxy_done;
  dispatch_sizes_pkg::data_t proxy_rdata;

  cpu_rotor i_cpu_rotor (
    .clk         (clk),
    .ext_rst_e   (ext_rst_e),
    .advance     (advance),
    .cpu_started (cpu_started),
    .cpu_ended   (cpu_ended),
    .cpu_sel     (cpu_sel)
  );

  mem_proxy i_mem_proxy (
    .clk        (clk),
    .ext_rst_e  (ext_rst_e),
    .go         (proxy_go),
    .we         (proxy_we),
    .addr       (proxy_addr),
    .wdata      (proxy_wdata),
    .done       (proxy_done),
    .rdata      (proxy_rdata),
    .mem_cyc    (mem_cyc),
    .mem_stb    (mem_stb),
    .mem_we     (mem_we),
    .mem_adr    (mem_adr),
    .mem_dat_wr (mem_dat_wr),
    .mem_dat_rd (mem_dat_rd),
    .mem_ack    (mem_ack)
  );

  dispatch_ctl i_dispatch_ctl (
    .clk           (clk),
    .ext_rst_e     (ext_rst_e),
    .cpu_sel       (cpu_sel),
    .proxy_done    (proxy_done),
    .proxy_rdata   (proxy_rdata),
    .advance       (advance),
    .cpu_started   (cpu_started),
    .cpu_ended     (cpu_ended),
    .proxy_go      (proxy_go),
    .proxy_we      (proxy_we),
    .proxy_addr    (proxy_addr),
    .proxy_wdata   (proxy_wdata),
    .cpu_q         (cpu_q),
    .cpu_index     (cpu_index),
    .ext_cpu_e     (ext_cpu_e),
    .cpu_msg       (cpu_msg),
    .read_q        (read_q),
    .write_q       (write_q),
    .cpu_addr      (cpu_addr),
    .cpu_wdata     (cpu_wdata),
    .read_dn       (read_dn),
    .write_dn      (write_dn),
    .cpu_rdata     (cpu_rdata),
    .ext_bus_q     (ext_bus_q),
    .ext_bus_allow (ext_bus_allow)
  );

endmodule

// File: dv/wb_mem_responder.sv
`timescale 1ns/1ps

module wb_mem_responder #(
  parameter dispatch_sizes_pkg::data_t FILL_KEY = 32'h0
) (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      cyc,
  input  logic                      stb,
  input  logic                      we,
  input  dispatch_sizes_pkg::addr_t adr,
  input  dispatch_sizes_pkg::data_t dat_wr,
  output dispatch_sizes_pkg::data_t dat_rd,
  output logic                      ack
);

  // sparse memory, untouched words read as address xor key
  dispatch_sizes_pkg::data_t mem [dispatch_sizes_pkg::addr_t];

  // cycles left before the next ack
  int wait_cnt;

  always @(posedge clk) begin
    if (rst) begin
      ack <= 1'b0;
      dat_rd <= '0;
      wait_cnt <= 0;
    end else if (ack) begin
      // single cycle ack, then draw a fresh delay
      ack <= 1'b0;
      wait_cnt <= $urandom_range(0, 5);
    end else if (cyc && stb) begin
      if (wait_cnt == 0) begin
        ack <= 1'b1;
        if (we) begin
          mem[adr] = dat_wr;
        end else if (mem.exists(adr)) begin
          dat_rd <= mem[adr];
        end else begin
          dat_rd <= adr ^ FILL_KEY;
        end
      end else begin
        wait_cnt <= wait_cnt - 1;
      end
    end
  end

endmodule

// File: dv/tb_dispatcher_of_cpus.sv
`timescale 1ns/1ps

module tb_dispatcher_of_cpus;

  // responder fill pattern for never-written words
  localparam dispatch_sizes_pkg::data_t FILL_KEY = 32'hA5C3_0F96;
  // cycle budget per stimulus line
  localparam int CYCLES_PER_LINE = 40;

  logic clk;
  logic ext_rst_e;
  logic cpu_q;
  dispatch_sizes_pkg::cpu_sel_u cpu_index;
  logic ext_cpu_e;
  dispatch_codes_pkg::cpu_msg_t cpu_msg;
  logic read_q;
  logic write_q;
  dispatch_sizes_pkg::addr_t cpu_addr;
  dispatch_sizes_pkg::data_t cpu_wdata;
  logic read_dn;
  logic write_dn;
  dispatch_sizes_pkg::data_t cpu_rdata;
  logic ext_bus_q;
  logic ext_bus_allow;
  logic mem_cyc;
  logic mem_stb;
  logic mem_we;
  dispatch_sizes_pkg::addr_t mem_adr;
  dispatch_sizes_pkg::data_t mem_dat_wr;
  dispatch_sizes_pkg::data_t mem_dat_rd;
  logic mem_ack;

  // stimulus lines, loaded before the run
  logic [7:0] cmd_q[$];
  dispatch_sizes_pkg::addr_t adr_q[$];
  dispatch_sizes_pkg::data_t dat_q[$];
  bit has_exp_q[$];
  int num_lines;
  bit loaded;

  // access window flags for the done pulse monitor
  logic rd_pending;
  logic wr_pending;

  // rotor model
  int m_active;
  int m_nonactive;
  int m_cur;
  bit m_offered;

  // previous bus sample for stability checks
  logic prev_stb;
  logic prev_ack;
  logic prev_we;
  dispatch_sizes_pkg::addr_t prev_adr;

  dispatcher_of_cpus i_dispatcher_of_cpus (
    .clk           (clk),
    .ext_rst_e     (ext_rst_e),
    .cpu_q         (cpu_q),
    .cpu_index     (cpu_index),
    .ext_cpu_e     (ext_cpu_e),
    .cpu_msg       (cpu_msg),
    .read_q        (read_q),
    .write_q       (write_q),
    .cpu_addr      (cpu_addr),
    .cpu_wdata     (cpu_wdata),
    .read_dn       (read_dn),
    .write_dn      (write_dn),
    .cpu_rdata     (cpu_rdata),
    .ext_bus_q     (ext_bus_q),
    .ext_bus_allow (ext_bus_allow),
    .mem_cyc       (mem_cyc),
    .mem_stb       (mem_stb),
    .mem_we        (mem_we),
    .mem_adr       (mem_adr),
    .mem_dat_wr    (mem_dat_wr),
    .mem_dat_rd    (mem_dat_rd),
    .mem_ack       (mem_ack)
  );

  wb_mem_responder #(.FILL_KEY(FILL_KEY)) i_wb_mem_responder (
    .clk     (clk),
    .rst     (ext_rst_e),
    .cyc     (mem_cyc),
    .stb     (mem_stb),
    .we      (mem_we),
    .adr     (mem_adr),
    .dat_wr  (mem_dat_wr),
    .dat_rd  (mem_dat_rd),
    .ack     (mem_ack)
  );

  initial begin
    clk = 1'b0;
  end

  always #4 clk = ~clk;

  task automatic stop_run(input string what);
    $display("%s", what);
    $display("*** TEST FAILED ***");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_sel(input string name, input dispatch_sizes_pkg::cpu_sel_u got,
                           input dispatch_sizes_pkg::cpu_sel_u exp);
    if (got.raw !== exp.raw) begin
      stop_run($sformatf("[ERROR] %s: got 0x%h, expected 0x%h", name, got.raw, exp.raw));
    end
  endtask

  task automatic check_data(input string name, input dispatch_sizes_pkg::data_t got,
                            input dispatch_sizes_pkg::data_t exp);
    if (got !== exp) begin
      stop_run($sformatf("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_addr(input string name, input dispatch_sizes_pkg::addr_t got,
                            input dispatch_sizes_pkg::addr_t exp);
    if (got !== exp) begin
      stop_run($sformatf("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      stop_run($sformatf("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  // offer to the waiting pool every other turn, else step round-robin
  function automatic dispatch_sizes_pkg::cpu_sel_u next_sel_model();
    dispatch_sizes_pkg::cpu_sel_u s;
    s = '0;
    if (m_nonactive > 0 && !m_offered) begin
      m_offered = 1'b1;
      s.fields.nonactive_pool = 1'b1;
    end else begin
      m_offered = 1'b0;
      if (m_active == 0 || m_cur >= m_active - 1) begin
        m_cur = 0;
      end else begin
        m_cur = m_cur + 1;
      end
      s.fields.active_pool = 1'b1;
      s.fields.cpu_number = dispatch_sizes_pkg::cpu_num_t'(m_cur);
    end
    return s;
  endfunction

  // each line holds a command letter, a hex address or cycle count and hex data
  task automatic read_stimulus();
    int fd;
    int n;
    string line;
    logic [7:0] c;
    dispatch_sizes_pkg::addr_t a;
    dispatch_sizes_pkg::data_t d;
    fd = $fopen("dv/dispatch_stimulus.txt", "r");
    if (fd == 0) begin
      stop_run("could not open the stimulus file dv/dispatch_stimulus.txt");
    end
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      c = 8'h0;
      a = '0;
      d = '0;
      n = $sscanf(line, " %c %h %h", c, a, d);
      if (n >= 1 && c != "#") begin
        cmd_q.push_back(c);
        adr_q.push_back(a);
        dat_q.push_back(d);
        has_exp_q.push_back(n == 3);
      end
    end
    $fclose(fd);
  endtask

  task automatic wait_for_turn();
    @(posedge clk);
    while (!cpu_q) begin
      @(posedge clk);
    end
  endtask

  // watchdog sized from the stimulus length
  initial begin
    wait (loaded);
    repeat (num_lines * CYCLES_PER_LINE + 20) @(posedge clk);
    stop_run("timeout: the run did not finish within the cycle budget");
  end

  // protocol monitor
  always @(posedge clk) begin
    if (!ext_rst_e) begin
      // pending drops on the done edge so a second high cycle trips this
      if (read_dn && !rd_pending) begin
        stop_run("read_dn was high outside a read access or longer than one cycle");
      end
      if (write_dn && !wr_pending) begin
        stop_run("write_dn was high outside a write access or longer than one cycle");
      end
      if (ext_bus_allow && mem_cyc) begin
        stop_run("mem_cyc was high while the external bus was granted");
      end
      // classic cycle keeps strobe and cycle together
      check_bit("mem_stb", mem_stb, mem_cyc);
      // held request until ack
      if (mem_stb && prev_stb && !prev_ack) begin
        check_addr("mem_adr", mem_adr, prev_adr);
        check_bit("mem_we", mem_we, prev_we);
      end
    end
    prev_stb <= mem_stb;
    prev_ack <= mem_ack;
    prev_we <= mem_we;
    prev_adr <= mem_adr;
  end

  initial begin
    int k;
    bit saw_allow;
    dispatch_sizes_pkg::data_t exp;
    void'($urandom(42));
    ext_rst_e <= 1'b1;
    ext_cpu_e <= 1'b0;
    cpu_msg <= dispatch_codes_pkg::CPU_R_NONE;
    read_q <= 1'b0;
    write_q <= 1'b0;
    cpu_addr <= '0;
    cpu_wdata <= '0;
    ext_bus_q <= 1'b0;
    rd_pending <= 1'b0;
    wr_pending <= 1'b0;
    m_active = 0;
    m_nonactive = dispatch_sizes_pkg::CPU_QUANTITY;
    m_cur = 0;
    m_offered = 1'b0;
    loaded = 1'b0;

    read_stimulus();
    num_lines = cmd_q.size();
    loaded = 1'b1;

    repeat (2) @(posedge clk);
    ext_rst_e <= 1'b0;
    // outputs straight out of reset
    check_bit("cpu_q", cpu_q, 1'b0);
    check_sel("cpu_index", cpu_index, '0);
    check_bit("read_dn", read_dn, 1'b0);
    check_bit("write_dn", write_dn, 1'b0);
    check_bit("mem_cyc", mem_cyc, 1'b0);
    check_bit("mem_stb", mem_stb, 1'b0);
    check_bit("ext_bus_allow", ext_bus_allow, 1'b0);

    for (k = 0; k < num_lines; k++) begin
      wait_for_turn();
      check_sel("cpu_index", cpu_index, next_sel_model());
      case (cmd_q[k])
        "R": begin
          read_q <= 1'b1;
          cpu_addr <= adr_q[k];
          rd_pending <= 1'b1;
          // no expected column means an untouched word
          exp = has_exp_q[k] ? dat_q[k] : (adr_q[k] ^ FILL_KEY);
          @(posedge clk);
          while (!read_dn) @(posedge clk);
          check_data("cpu_rdata", cpu_rdata, exp);
          read_q <= 1'b0;
          rd_pending <= 1'b0;
        end
        "W": begin
          write_q <= 1'b1;
          cpu_addr <= adr_q[k];
          cpu_wdata <= dat_q[k];
          wr_pending <= 1'b1;
          @(posedge clk);
          while (!write_dn) @(posedge clk);
          write_q <= 1'b0;
          wr_pending <= 1'b0;
        end
        "S", "E": begin
          ext_cpu_e <= 1'b1;
          cpu_msg <= (cmd_q[k] == "S") ? dispatch_codes_pkg::CPU_R_START
                                        : dispatch_codes_pkg::CPU_R_END;
          @(posedge clk);
          ext_cpu_e <= 1'b0;
          if (cmd_q[k] == "S") begin
            m_active = m_active + 1;
            m_nonactive = m_nonactive - 1;
          end else begin
            m_active = m_active - 1;
            m_nonactive = m_nonactive + 1;
          end
        end
        "B": begin
          // give the turn back and ask for the bus in the same cycle
          ext_cpu_e <= 1'b1;
          cpu_msg <= dispatch_codes_pkg::CPU_R_NONE;
          ext_bus_q <= 1'b1;
          saw_allow = 1'b0;
          @(posedge clk);
          ext_cpu_e <= 1'b0;
          // hold time sits in the address column
          repeat (int'(adr_q[k]) - 1) begin
            @(posedge clk);
            if (ext_bus_allow) saw_allow = 1'b1;
          end
          ext_bus_q <= 1'b0;
          if (!saw_allow) begin
            stop_run("ext_bus_allow never rose during the external bus request");
          end
          // request seen low on the next edge, allow low one edge later
          @(posedge clk);
          @(posedge clk);
          check_bit("ext_bus_allow", ext_bus_allow, 1'b0);
        end
        default: begin
          stop_run($sformatf("unknown command in stimulus line %0d", k));
        end
      endcase
    end

    // one more turn shows the loop carries on
    wait_for_turn();
    check_sel("cpu_index", cpu_index, next_sel_model());
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

// File: dv/dispatch_stimulus.txt
# cmd addr(hex) data(hex): R read with expected data, or fill value when data is left out
# W write, S start message, E end message, B bus request held for addr-column cycles
S
W 00000100 DEADBEEF
S
R 00000100 DEADBEEF
R 00000200
B 6
W 00000200 12345678
R 00000200 12345678
S
W 00000304 0BADF00D
R 00000304 0BADF00D
E
B 8
R 00001000
W 00000100 CAFEF00D
R 00000100 CAFEF00D
S
R 00000008
W 0000FFFC 55AA55AA
E
R 0000FFFC 55AA55AA
B 5

// File: dispatcher_of_cpus.f
design/dispatch_sizes_pkg.sv
design/dispatch_codes_pkg.sv
design/cpu_rotor.sv
design/mem_proxy.sv
design/dispatch_ctl.sv
design/dispatcher_of_cpus.sv
dv/wb_mem_responder.sv
dv/tb_dispatcher_of_cpus.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --timing
TOP       ?= tb_dispatcher_of_cpus
RTL_TOP   ?= dispatcher_of_cpus
FILELIST  ?= dispatcher_of_cpus.f
OBJ_DIR   ?= obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(TOP)

$(OBJ_DIR)/V$(TOP): $(shell cat $(FILELIST))
	$(VERILATOR) --binary $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
